// File: design/dpath_pkg.sv
// ----------------------------------------------------------------------
// Shared widths, select encodings and stage payloads of the datapath
// Encodings must match the external control unit bit for bit
// ----------------------------------------------------------------------

package dpath_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int ROB_AW = 5;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [ROB_AW-1:0] rob_slot_t;

  // ----------------------------------------------------------------------
  // Select encodings
  // ----------------------------------------------------------------------

  typedef enum logic [2:0] {
    BYP_RF  = 3'd0,
    BYP_X   = 3'd1,
    BYP_M   = 3'd2,
    BYP_W   = 3'd3,
    BYP_ROB = 3'd4
  } byp_sel_e;

  typedef enum logic [1:0] {
    OP0_RS   = 2'd0,
    OP0_PC   = 2'd1,
    OP0_PC4  = 2'd2,
    OP0_ZERO = 2'd3
  } op0_sel_e;

  typedef enum logic [2:0] {
    OP1_RS     = 3'd0,
    OP1_SHAMT  = 3'd1,
    OP1_IMM_U  = 3'd2,
    OP1_IMM_SB = 3'd3,
    OP1_IMM_I  = 3'd4,
    OP1_IMM_S  = 3'd5,
    OP1_ZERO   = 3'd6
  } op1_sel_e;

  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_SLL   = 4'd2,
    ALU_SLT   = 4'd3,
    ALU_SLTU  = 4'd4,
    ALU_XOR   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_OR    = 4'd8,
    ALU_AND   = 4'd9,
    ALU_COPY1 = 4'd10
  } alu_fn_e;

  // Same order as the load response mux select
  typedef enum logic [2:0] {
    LD_W  = 3'd0,
    LD_B  = 3'd1,
    LD_BU = 3'd2,
    LD_H  = 3'd3,
    LD_HU = 3'd4
  } load_e;

  // ----------------------------------------------------------------------
  // Stage payloads
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic      valid;
    op0_sel_e  op0_sel;
    op1_sel_e  op1_sel;
    byp_sel_e  byp0_sel;
    byp_sel_e  byp1_sel;
    rob_slot_t byp0_slot;
    rob_slot_t byp1_slot;
    alu_fn_e   alu_fn;
    logic      is_load;
    load_e     load_kind;
    rob_slot_t rob_slot;
  } issue_ctrl_t;

  typedef struct packed {
    logic      valid;
    alu_fn_e   alu_fn;
    logic      is_load;
    load_e     load_kind;
    rob_slot_t rob_slot;
    word_t     op0;
    word_t     op1;
    word_t     store_data;
  } x_stage_t;

  typedef struct packed {
    logic      valid;
    logic      is_load;
    load_e     load_kind;
    rob_slot_t rob_slot;
    word_t     alu_result;
  } m_stage_t;

  typedef struct packed {
    logic      valid;
    rob_slot_t rob_slot;
    word_t     result;
  } w_stage_t;

  typedef struct packed {
    logic eq;
    logic ne;
    logic lt;
    logic ltu;
    logic ge;
    logic geu;
  } branch_cond_t;

endpackage

// File: design/dpath_top.sv
// ----------------------------------------------------------------------
// Single-lane integer datapath, Issue to commit, no stalls
// Control unit outside; fixed latency of three cycles to Writeback
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module dpath_top #(
  parameter int ROB_DEPTH = 32
) (
  input  logic                    clk,
  input  logic                    reset,
  input  dpath_pkg::word_t        instr_i,
  input  dpath_pkg::word_t        pc_i,
  input  dpath_pkg::issue_ctrl_t  ctrl_i,
  input  logic                    commit_en_i,
  input  dpath_pkg::rob_slot_t    commit_slot_i,
  input  dpath_pkg::reg_addr_t    commit_waddr_i,
  input  dpath_pkg::word_t        dmem_rdata_i,
  output dpath_pkg::word_t        dmem_addr_o,
  output dpath_pkg::word_t        dmem_wdata_o,
  output dpath_pkg::branch_cond_t branch_cond_o,
  output logic                    wb_valid_o,
  output dpath_pkg::word_t        wb_result_o
);

  dpath_pkg::reg_addr_t rs1;
  dpath_pkg::reg_addr_t rs2;
  dpath_pkg::word_t     rf_rdata0;
  dpath_pkg::word_t     rf_rdata1;
  dpath_pkg::word_t     rob_rdata0;
  dpath_pkg::word_t     rob_rdata1;
  dpath_pkg::word_t     commit_data;
  dpath_pkg::word_t     alu_result;
  dpath_pkg::word_t     mem_result;
  dpath_pkg::x_stage_t  x_stage;
  dpath_pkg::m_stage_t  m_stage;
  dpath_pkg::w_stage_t  w_stage;

  // ----------------------------------------------------------------------
  // Register file, written from the commit port
  // ----------------------------------------------------------------------

  regfile i_regfile (
    .clk      (clk),
    .raddr0_i (rs1),
    .rdata0_o (rf_rdata0),
    .raddr1_i (rs2),
    .rdata1_o (rf_rdata1),
    .wen_i    (commit_en_i),
    .waddr_i  (commit_waddr_i),
    .wdata_i  (commit_data)
  );

  // ----------------------------------------------------------------------
  // Pipeline stages
  // ----------------------------------------------------------------------

  issue_stage i_issue (
    .clk          (clk),
    .reset        (reset),
    .instr_i      (instr_i),
    .pc_i         (pc_i),
    .ctrl_i       (ctrl_i),
    .rf_rdata0_i  (rf_rdata0),
    .rf_rdata1_i  (rf_rdata1),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .fwd_x_i      (alu_result),
    .fwd_m_i      (mem_result),
    .fwd_w_i      (w_stage.result),
    .rob_rdata0_i (rob_rdata0),
    .rob_rdata1_i (rob_rdata1),
    .x_o          (x_stage)
  );

  execute_stage i_execute (
    .clk           (clk),
    .reset         (reset),
    .x_i           (x_stage),
    .alu_result_o  (alu_result),
    .branch_cond_o (branch_cond_o),
    .dmem_addr_o   (dmem_addr_o),
    .dmem_wdata_o  (dmem_wdata_o),
    .m_o           (m_stage)
  );

  memory_stage i_memory (
    .clk          (clk),
    .reset        (reset),
    .m_i          (m_stage),
    .dmem_rdata_i (dmem_rdata_i),
    .result_o     (mem_result),
    .w_o          (w_stage)
  );

  // Writeback fill and commit read
  rob_commit #(
    .ROB_DEPTH (ROB_DEPTH)
  ) i_rob (
    .clk           (clk),
    .w_i           (w_stage),
    .byp0_slot_i   (ctrl_i.byp0_slot),
    .byp1_slot_i   (ctrl_i.byp1_slot),
    .byp0_data_o   (rob_rdata0),
    .byp1_data_o   (rob_rdata1),
    .commit_slot_i (commit_slot_i),
    .commit_data_o (commit_data)
  );

  assign wb_valid_o  = w_stage.valid;
  assign wb_result_o = w_stage.result;

endmodule

// File: design/execute_stage.sv
// ----------------------------------------------------------------------
// Execute stage: ALU, branch flags and data memory request
// Branch flags assume the control unit picked rs1 and rs2 as operands
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module execute_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  dpath_pkg::x_stage_t     x_i,
  output dpath_pkg::word_t        alu_result_o,
  output dpath_pkg::branch_cond_t branch_cond_o,
  output dpath_pkg::word_t        dmem_addr_o,
  output dpath_pkg::word_t        dmem_wdata_o,
  output dpath_pkg::m_stage_t     m_o
);

  dpath_pkg::word_t    alu_result;
  dpath_pkg::word_t    diff;
  logic [4:0]          shamt;
  logic                diff_signs;
  dpath_pkg::m_stage_t m_q;

  assign diff  = x_i.op0 - x_i.op1;
  assign shamt = x_i.op1[4:0];

  // ----------------------------------------------------------------------
  // ALU
  // ----------------------------------------------------------------------

  always_comb begin
    case (x_i.alu_fn)
      dpath_pkg::ALU_SUB:   alu_result = diff;
      dpath_pkg::ALU_SLL:   alu_result = x_i.op0 << shamt;
      dpath_pkg::ALU_SLT:   alu_result = {31'b0, $signed(x_i.op0) < $signed(x_i.op1)};
      dpath_pkg::ALU_SLTU:  alu_result = {31'b0, x_i.op0 < x_i.op1};
      dpath_pkg::ALU_XOR:   alu_result = x_i.op0 ^ x_i.op1;
      dpath_pkg::ALU_SRL:   alu_result = x_i.op0 >> shamt;
      dpath_pkg::ALU_SRA:   alu_result = dpath_pkg::word_t'($signed(x_i.op0) >>> shamt);
      dpath_pkg::ALU_OR:    alu_result = x_i.op0 | x_i.op1;
      dpath_pkg::ALU_AND:   alu_result = x_i.op0 & x_i.op1;
      dpath_pkg::ALU_COPY1: alu_result = x_i.op1;
      default:              alu_result = x_i.op0 + x_i.op1;
    endcase
  end

  // Sign of the difference decides unless the operand signs differ
  assign diff_signs = x_i.op0[31] ^ x_i.op1[31];

  assign branch_cond_o.eq  = (diff == '0);
  assign branch_cond_o.ne  = (diff != '0);
  assign branch_cond_o.lt  = diff_signs ? x_i.op0[31] : diff[31];
  assign branch_cond_o.ltu = diff_signs ? x_i.op1[31] : diff[31];
  assign branch_cond_o.ge  = diff_signs ? x_i.op1[31] : ~diff[31];
  assign branch_cond_o.geu = diff_signs ? x_i.op0[31] : ~diff[31];

  assign alu_result_o = alu_result;

  // Response comes back in Memory one cycle later
  assign dmem_addr_o  = alu_result;
  assign dmem_wdata_o = x_i.store_data;

  // ----------------------------------------------------------------------
  // X to M register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    m_q.is_load    <= x_i.is_load;
    m_q.load_kind  <= x_i.load_kind;
    m_q.rob_slot   <= x_i.rob_slot;
    m_q.alu_result <= alu_result;
    if (reset) begin
      m_q.valid <= 1'b0;
    end else begin
      m_q.valid <= x_i.valid;
    end
  end

  assign m_o = m_q;

endmodule

// File: design/issue_stage.sv
// ----------------------------------------------------------------------
// Issue stage: immediate decode, source bypass and operand selects
// Selects come from the external control unit with no checking here
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module issue_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  dpath_pkg::word_t       instr_i,
  input  dpath_pkg::word_t       pc_i,
  input  dpath_pkg::issue_ctrl_t ctrl_i,
  input  dpath_pkg::word_t       rf_rdata0_i,
  input  dpath_pkg::word_t       rf_rdata1_i,
  output dpath_pkg::reg_addr_t   rs1_o,
  output dpath_pkg::reg_addr_t   rs2_o,
  input  dpath_pkg::word_t       fwd_x_i,
  input  dpath_pkg::word_t       fwd_m_i,
  input  dpath_pkg::word_t       fwd_w_i,
  input  dpath_pkg::word_t       rob_rdata0_i,
  input  dpath_pkg::word_t       rob_rdata1_i,
  output dpath_pkg::x_stage_t    x_o
);

  dpath_pkg::word_t    shamt;
  dpath_pkg::word_t    imm_i;
  dpath_pkg::word_t    imm_s;
  dpath_pkg::word_t    imm_sb;
  dpath_pkg::word_t    imm_u;
  dpath_pkg::word_t    rs1_val;
  dpath_pkg::word_t    rs2_val;
  dpath_pkg::word_t    op0;
  dpath_pkg::word_t    op1;
  dpath_pkg::x_stage_t x_d;
  dpath_pkg::x_stage_t x_q;

  // One bypass point per source
  function automatic dpath_pkg::word_t pick_src(
    input dpath_pkg::byp_sel_e sel,
    input dpath_pkg::word_t    rf_data,
    input dpath_pkg::word_t    x_data,
    input dpath_pkg::word_t    m_data,
    input dpath_pkg::word_t    w_data,
    input dpath_pkg::word_t    rob_data
  );
    case (sel)
      dpath_pkg::BYP_X:   return x_data;
      dpath_pkg::BYP_M:   return m_data;
      dpath_pkg::BYP_W:   return w_data;
      dpath_pkg::BYP_ROB: return rob_data;
      default:            return rf_data;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Instruction fields, RV32I immediate formats
  // ----------------------------------------------------------------------

  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];
  assign shamt  = dpath_pkg::word_t'(instr_i[24:20]);
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
  assign imm_u  = {instr_i[31:12], 12'b0};

  assign rs1_val = pick_src(ctrl_i.byp0_sel, rf_rdata0_i, fwd_x_i, fwd_m_i, fwd_w_i,
                            rob_rdata0_i);
  assign rs2_val = pick_src(ctrl_i.byp1_sel, rf_rdata1_i, fwd_x_i, fwd_m_i, fwd_w_i,
                            rob_rdata1_i);

  // Operand muxes
  always_comb begin
    case (ctrl_i.op0_sel)
      dpath_pkg::OP0_PC:   op0 = pc_i;
      dpath_pkg::OP0_PC4:  op0 = pc_i + 32'd4;
      dpath_pkg::OP0_ZERO: op0 = '0;
      default:             op0 = rs1_val;
    endcase
  end

  always_comb begin
    case (ctrl_i.op1_sel)
      dpath_pkg::OP1_SHAMT:  op1 = shamt;
      dpath_pkg::OP1_IMM_U:  op1 = imm_u;
      dpath_pkg::OP1_IMM_SB: op1 = imm_sb;
      dpath_pkg::OP1_IMM_I:  op1 = imm_i;
      dpath_pkg::OP1_IMM_S:  op1 = imm_s;
      dpath_pkg::OP1_ZERO:   op1 = '0;
      default:               op1 = rs2_val;
    endcase
  end

  // ----------------------------------------------------------------------
  // I to X register
  // ----------------------------------------------------------------------

  always_comb begin
    x_d.valid      = ctrl_i.valid;
    x_d.alu_fn     = ctrl_i.alu_fn;
    x_d.is_load    = ctrl_i.is_load;
    x_d.load_kind  = ctrl_i.load_kind;
    x_d.rob_slot   = ctrl_i.rob_slot;
    x_d.op0        = op0;
    x_d.op1        = op1;
    // Stores always take bypassed rs2
    x_d.store_data = rs2_val;
  end

  always_ff @(posedge clk) begin
    x_q <= x_d;
    if (reset) begin
      x_q.valid <= 1'b0;
    end
  end

  assign x_o = x_q;

endmodule

// File: design/memory_stage.sv
// ----------------------------------------------------------------------
// Memory stage: load extension and result select
// Load data must be valid in the cycle after the request, no wait states
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module memory_stage (
  input  logic                clk,
  input  logic                reset,
  input  dpath_pkg::m_stage_t m_i,
  input  dpath_pkg::word_t    dmem_rdata_i,
  output dpath_pkg::word_t    result_o,
  output dpath_pkg::w_stage_t w_o
);

  dpath_pkg::word_t    load_val;
  dpath_pkg::word_t    result;
  dpath_pkg::w_stage_t w_q;

  // Only the low byte or halfword is used for sub-word loads
  always_comb begin
    case (m_i.load_kind)
      dpath_pkg::LD_B:  load_val = {{24{dmem_rdata_i[7]}}, dmem_rdata_i[7:0]};
      dpath_pkg::LD_BU: load_val = {24'b0, dmem_rdata_i[7:0]};
      dpath_pkg::LD_H:  load_val = {{16{dmem_rdata_i[15]}}, dmem_rdata_i[15:0]};
      dpath_pkg::LD_HU: load_val = {16'b0, dmem_rdata_i[15:0]};
      default:          load_val = dmem_rdata_i;
    endcase
  end

  assign result   = m_i.is_load ? load_val : m_i.alu_result;
  assign result_o = result;

  // ----------------------------------------------------------------------
  // M to W register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    w_q.rob_slot <= m_i.rob_slot;
    w_q.result   <= result;
    if (reset) begin
      w_q.valid <= 1'b0;
    end else begin
      w_q.valid <= m_i.valid;
    end
  end

  assign w_o = w_q;

endmodule

// File: design/regfile.sv
// ----------------------------------------------------------------------
// Architectural register file, two async reads and one write
// A read in the cycle of a write to the same register sees the old value
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module regfile (
  input  logic                 clk,
  input  dpath_pkg::reg_addr_t raddr0_i,
  output dpath_pkg::word_t     rdata0_o,
  input  dpath_pkg::reg_addr_t raddr1_i,
  output dpath_pkg::word_t     rdata1_o,
  input  logic                 wen_i,
  input  dpath_pkg::reg_addr_t waddr_i,
  input  dpath_pkg::word_t     wdata_i
);

  localparam int NUM_REGS = 2 ** dpath_pkg::REG_AW;

  dpath_pkg::word_t regs [NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wen_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero whatever the array holds
  assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];

endmodule

// File: design/rob_commit.sv
// ----------------------------------------------------------------------
// Reorder buffer data array: one fill port, three async read ports
// ROB_DEPTH must be a power of two from 2 up to 2**ROB_AW
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module rob_commit #(
  parameter int ROB_DEPTH = 32
) (
  input  logic                 clk,
  input  dpath_pkg::w_stage_t  w_i,
  input  dpath_pkg::rob_slot_t byp0_slot_i,
  input  dpath_pkg::rob_slot_t byp1_slot_i,
  output dpath_pkg::word_t     byp0_data_o,
  output dpath_pkg::word_t     byp1_data_o,
  input  dpath_pkg::rob_slot_t commit_slot_i,
  output dpath_pkg::word_t     commit_data_o
);

  // Slots above the depth alias onto the low index bits
  localparam int IDX_W = $clog2(ROB_DEPTH);

  dpath_pkg::word_t rob_data [ROB_DEPTH];

  // Fill from Writeback
  always_ff @(posedge clk) begin
    if (w_i.valid) begin
      rob_data[w_i.rob_slot[IDX_W-1:0]] <= w_i.result;
    end
  end

  // Bypass reads for Issue
  assign byp0_data_o = rob_data[byp0_slot_i[IDX_W-1:0]];
  assign byp1_data_o = rob_data[byp1_slot_i[IDX_W-1:0]];

  // Commit read feeds the register file write port
  assign commit_data_o = rob_data[commit_slot_i[IDX_W-1:0]];

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator from the project root
set -u
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_dpath -f tb.f -o tb_dpath_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_dpath_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "PASS: all tests" sim.log; then
  exit 0
fi
exit 1

// File: tb.f
design/dpath_pkg.sv
design/regfile.sv
design/issue_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/rob_commit.sv
design/dpath_top.sv
test/dpath_sva.sv
test/tb_dpath.sv

// File: test/dpath_input.txt
# name instr pc valid op0 op1 byp0 byp1 slot0 slot1 fn load kind rob_slot dmem
# commit_en commit_slot commit_waddr check(1 flags 2 addr 4 wdata 8 result) flags addr wdata result
add_imm 12300000 00000000 1 3 4 0 0 00 00 0 0 0 01 00000000 0 00 00 b 1c 00000123 00000000 00000123
lui_imm 80000000 00000000 1 3 2 0 0 00 00 a 0 0 02 00000000 0 00 00 f 16 80000000 00000000 80000000
sub_neg FFF00000 00000000 1 3 4 0 0 00 00 1 0 0 03 00000000 0 00 00 b 16 00000001 00000000 00000001
fwd_x 00500000 00000000 1 0 4 1 0 00 00 0 0 0 04 00000000 0 00 00 b 1c 00000006 00000000 00000006
fwd_m 00000000 00000000 1 0 0 2 1 00 00 2 0 0 05 00000000 0 00 00 f 1c 00000040 00000006 00000040
fwd_w 00000000 00000000 1 0 0 3 2 00 00 1 0 0 06 00000000 0 00 00 f 1c FFFFFFFB 00000006 FFFFFFFB
rob_read 00000000 00000000 1 0 0 4 4 01 02 0 0 0 07 00000000 1 01 05 f 16 80000123 80000000 80000123
xor_imm 0F028000 00000000 1 0 4 0 0 00 00 5 0 0 08 00000000 1 02 06 b 13 000001D3 00000000 000001D3
sra_shamt 00430000 00000000 1 0 1 0 0 00 00 7 0 0 09 00000000 1 03 07 b 19 F8000000 00000000 F8000000
srl_shamt 00430000 00000000 1 0 1 0 0 00 00 6 0 0 0a 00000000 1 01 00 b 19 08000000 00000000 08000000
x0_zero 00700000 00000000 1 0 0 0 0 00 00 8 0 0 0b 00000000 0 00 00 f 1c 00000001 00000001 00000001
slt_neg 00730000 00000000 1 0 0 0 0 00 00 3 0 0 0c 00000000 0 00 00 f 19 00000001 00000001 00000001
sltu_neg 00730000 00000000 1 0 0 0 0 00 00 4 0 0 0d 00000000 0 00 00 f 19 00000000 00000001 00000000
and_rs 00728000 00000000 1 0 0 0 0 00 00 9 0 0 0e 00000000 0 00 00 f 13 00000001 00000001 00000001
beq_equal 00738000 00000000 1 0 0 0 0 00 00 1 0 0 0f 00000000 0 00 00 f 23 00000000 00000001 00000000
pc_plus4 00000000 00001000 1 2 6 0 0 00 00 0 0 0 10 00000000 0 00 00 f 13 00001004 00000000 00001004
auipc 12345000 00001000 1 1 2 0 0 00 00 0 0 0 11 00000000 0 00 00 b 1c 12346000 00000000 12346000
lw 01028000 00000000 1 0 4 0 0 00 00 0 1 0 12 8765F0A5 0 00 00 b 13 00000133 00000000 8765F0A5
lb 01028000 00000000 1 0 4 0 0 00 00 0 1 1 13 8765F0A5 0 00 00 b 13 00000133 00000000 FFFFFFA5
lbu 01028000 00000000 1 0 4 0 0 00 00 0 1 2 14 8765F0A5 0 00 00 b 13 00000133 00000000 000000A5
lh 01028000 00000000 1 0 4 0 0 00 00 0 1 3 15 8765F0A5 0 00 00 b 13 00000133 00000000 FFFFF0A5
lhu 01028000 00000000 1 0 4 0 0 00 00 0 1 4 16 8765F0A5 0 00 00 b 13 00000133 00000000 0000F0A5
sw 00728400 00000000 1 0 5 0 0 00 00 0 0 0 17 00000000 0 00 00 f 13 0000012B 00000001 0000012B
load_fwd_m 00000000 00000000 1 0 6 2 0 00 00 0 0 0 18 00000000 0 00 00 b 13 0000F0A5 00000000 0000F0A5
bubble 00000000 00000000 0 0 0 0 0 00 00 0 0 0 00 00000000 0 00 00 0 00 00000000 00000000 00000000
both_neg 00030000 00000000 1 0 0 0 4 00 06 1 0 0 19 00000000 0 00 00 f 1c 80000005 FFFFFFFB 80000005

// File: test/dpath_sva.sv
// ----------------------------------------------------------------------
// Pipeline checks bound to dpath_top, three-cycle Writeback latency
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module dpath_sva (
  input logic                    clk,
  input logic                    reset,
  input logic                    ctrl_valid,
  input logic                    wb_valid,
  input dpath_pkg::branch_cond_t branch_cond
);

  // Valid bits clear within three edges of reset
  assert property (@(posedge clk)
    (reset && $past(reset) && $past(reset, 2) && $past(reset, 3)) |-> !wb_valid)
    else $error("wb_valid high while reset is held");

  assert property (@(posedge clk) disable iff (reset)
    wb_valid == $past(ctrl_valid, 3))
    else $error("wb_valid does not follow Issue valid three cycles earlier");

  assert property (@(posedge clk) disable iff (reset)
    branch_cond.ne == !branch_cond.eq)
    else $error("branch flag ne is not the inverse of eq");

endmodule

bind dpath_top dpath_sva i_sva (
  .clk         (clk),
  .reset       (reset),
  .ctrl_valid  (ctrl_i.valid),
  .wb_valid    (wb_valid_o),
  .branch_cond (branch_cond_o)
);

// File: test/tb_dpath.sv
// ----------------------------------------------------------------------
// Datapath testbench, one test line per cycle from test/dpath_input.txt
// Run from the project root so the stimulus file path resolves
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tb_dpath;

  localparam int MAX_TESTS    = 64;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;

  logic                    clk;
  logic                    reset;
  dpath_pkg::word_t        instr;
  dpath_pkg::word_t        pc;
  dpath_pkg::issue_ctrl_t  ctrl;
  logic                    commit_en;
  dpath_pkg::rob_slot_t    commit_slot;
  dpath_pkg::reg_addr_t    commit_waddr;
  dpath_pkg::word_t        dmem_rdata;
  dpath_pkg::word_t        dmem_addr;
  dpath_pkg::word_t        dmem_wdata;
  dpath_pkg::branch_cond_t branch_cond;
  logic                    wb_valid;
  dpath_pkg::word_t        wb_result;

  // Test table, one entry per input line
  string                   t_name   [MAX_TESTS];
  dpath_pkg::word_t        t_instr  [MAX_TESTS];
  dpath_pkg::word_t        t_pc     [MAX_TESTS];
  dpath_pkg::issue_ctrl_t  t_ctrl   [MAX_TESTS];
  dpath_pkg::word_t        t_dmem   [MAX_TESTS];
  logic                    t_cen    [MAX_TESTS];
  dpath_pkg::rob_slot_t    t_cslot  [MAX_TESTS];
  dpath_pkg::reg_addr_t    t_cwaddr [MAX_TESTS];
  logic [3:0]              t_chk    [MAX_TESTS];
  dpath_pkg::branch_cond_t t_flags  [MAX_TESTS];
  dpath_pkg::word_t        t_addr   [MAX_TESTS];
  dpath_pkg::word_t        t_wdata  [MAX_TESTS];
  dpath_pkg::word_t        t_result [MAX_TESTS];
  int                      t_errs   [MAX_TESTS];

  int   num_tests;
  int   error_count;
  int   pass_count;
  logic loaded;

  always #(CLK_PERIOD / 2) clk = ~clk;

  dpath_top #(
    .ROB_DEPTH (32)
  ) i_dut (
    .clk            (clk),
    .reset          (reset),
    .instr_i        (instr),
    .pc_i           (pc),
    .ctrl_i         (ctrl),
    .commit_en_i    (commit_en),
    .commit_slot_i  (commit_slot),
    .commit_waddr_i (commit_waddr),
    .dmem_rdata_i   (dmem_rdata),
    .dmem_addr_o    (dmem_addr),
    .dmem_wdata_o   (dmem_wdata),
    .branch_cond_o  (branch_cond),
    .wb_valid_o     (wb_valid),
    .wb_result_o    (wb_result)
  );

  // ----------------------------------------------------------------------
  // Stimulus file
  // ----------------------------------------------------------------------

  task automatic load_tests();
    int          fd;
    int          rc;
    string       line;
    string       nm;
    logic [31:0] f_instr, f_pc, f_v, f_op0, f_op1, f_b0, f_b1, f_s0, f_s1;
    logic [31:0] f_fn, f_ld, f_lk, f_slot, f_dmem, f_cen, f_cslot, f_cwa;
    logic [31:0] f_chk, f_flags, f_addr, f_wdata, f_res;
    fd = $fopen("test/dpath_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file test/dpath_input.txt");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      // Skip blank and comment lines
      if (line.len() < 2 || line[0] == 8'h23) continue;
      rc = $sscanf(line,
        "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        nm, f_instr, f_pc, f_v, f_op0, f_op1, f_b0, f_b1, f_s0, f_s1, f_fn, f_ld,
        f_lk, f_slot, f_dmem, f_cen, f_cslot, f_cwa, f_chk, f_flags, f_addr,
        f_wdata, f_res);
      if (rc != 23) begin
        $display("malformed stimulus line: %s", line);
        error_count++;
      end else if (num_tests >= MAX_TESTS) begin
        $display("too many stimulus lines, only %0d are allowed", MAX_TESTS);
        error_count++;
      end else begin
        t_name[num_tests]             = nm;
        t_instr[num_tests]            = f_instr;
        t_pc[num_tests]               = f_pc;
        t_ctrl[num_tests].valid       = f_v[0];
        t_ctrl[num_tests].op0_sel     = dpath_pkg::op0_sel_e'(f_op0[1:0]);
        t_ctrl[num_tests].op1_sel     = dpath_pkg::op1_sel_e'(f_op1[2:0]);
        t_ctrl[num_tests].byp0_sel    = dpath_pkg::byp_sel_e'(f_b0[2:0]);
        t_ctrl[num_tests].byp1_sel    = dpath_pkg::byp_sel_e'(f_b1[2:0]);
        t_ctrl[num_tests].byp0_slot   = f_s0[4:0];
        t_ctrl[num_tests].byp1_slot   = f_s1[4:0];
        t_ctrl[num_tests].alu_fn      = dpath_pkg::alu_fn_e'(f_fn[3:0]);
        t_ctrl[num_tests].is_load     = f_ld[0];
        t_ctrl[num_tests].load_kind   = dpath_pkg::load_e'(f_lk[2:0]);
        t_ctrl[num_tests].rob_slot    = f_slot[4:0];
        t_dmem[num_tests]             = f_dmem;
        t_cen[num_tests]              = f_cen[0];
        t_cslot[num_tests]            = f_cslot[4:0];
        t_cwaddr[num_tests]           = f_cwa[4:0];
        t_chk[num_tests]              = f_chk[3:0];
        t_flags[num_tests]            = dpath_pkg::branch_cond_t'(f_flags[5:0]);
        t_addr[num_tests]             = f_addr;
        t_wdata[num_tests]            = f_wdata;
        t_result[num_tests]           = f_res;
        t_errs[num_tests]             = 0;
        num_tests++;
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------

  task automatic compare_flags(input int idx, input dpath_pkg::branch_cond_t exp,
                               input dpath_pkg::branch_cond_t act);
    if (act !== exp) begin
      $display("error %s branch flags: expected %06b, actual %06b", t_name[idx], exp, act);
      t_errs[idx]++;
      error_count++;
    end
  endtask

  task automatic compare_mem_word(input int idx, input string what,
                                  input dpath_pkg::word_t exp, input dpath_pkg::word_t act);
    if (act !== exp) begin
      $display("error %s %s: expected %08h, actual %08h", t_name[idx], what, exp, act);
      t_errs[idx]++;
      error_count++;
    end
  endtask

  task automatic compare_valid(input int idx, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s writeback valid: expected %b, actual %b", t_name[idx], exp, act);
      t_errs[idx]++;
      error_count++;
    end
  endtask

  task automatic compare_result(input int idx, input dpath_pkg::word_t exp,
                                input dpath_pkg::word_t act);
    if (act !== exp) begin
      $display("error %s result: expected %08h, actual %08h", t_name[idx], exp, act);
      t_errs[idx]++;
      error_count++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Per-cycle drive and check
  // ----------------------------------------------------------------------

  // Line c enters Issue, line c-2 is in Memory and takes its load data
  task automatic drive_cycle(input int c);
    if (c < num_tests) begin
      instr        = t_instr[c];
      pc           = t_pc[c];
      ctrl         = t_ctrl[c];
      commit_en    = t_cen[c];
      commit_slot  = t_cslot[c];
      commit_waddr = t_cwaddr[c];
    end else begin
      instr        = '0;
      pc           = '0;
      ctrl         = '0;
      commit_en    = 1'b0;
      commit_slot  = '0;
      commit_waddr = '0;
    end
    if (c >= 2 && c - 2 < num_tests) begin
      dmem_rdata = t_dmem[c - 2];
    end else begin
      dmem_rdata = '0;
    end
  endtask

  // Execute holds line c-1, Writeback holds line c-3
  task automatic check_cycle(input int c);
    int xi;
    int wi;
    xi = c - 1;
    wi = c - 3;
    if (xi >= 0 && xi < num_tests) begin
      if (t_chk[xi][0]) compare_flags(xi, t_flags[xi], branch_cond);
      if (t_chk[xi][1]) compare_mem_word(xi, "address", t_addr[xi], dmem_addr);
      if (t_chk[xi][2]) compare_mem_word(xi, "store data", t_wdata[xi], dmem_wdata);
    end
    if (wi >= 0 && wi < num_tests) begin
      compare_valid(wi, t_ctrl[wi].valid, wb_valid);
      if (t_ctrl[wi].valid && t_chk[wi][3]) begin
        compare_result(wi, t_result[wi], wb_result);
      end
      if (t_errs[wi] == 0) begin
        pass_count++;
        $display("test %-12s passed", t_name[wi]);
      end else begin
        $display("test %-12s failed", t_name[wi]);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------------------

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    instr        = '0;
    pc           = '0;
    ctrl         = '0;
    commit_en    = 1'b0;
    commit_slot  = '0;
    commit_waddr = '0;
    dmem_rdata   = '0;
    num_tests    = 0;
    error_count  = 0;
    pass_count   = 0;
    loaded       = 1'b0;
    load_tests();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    for (int c = 0; c < num_tests + 3; c++) begin
      @(posedge clk);
      #1;
      reset = 1'b0;
      drive_cycle(c);
      #2;
      check_cycle(c);
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors", num_tests,
             pass_count, num_tests - pass_count, error_count);
    if (error_count == 0 && num_tests > 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    #((num_tests + 40) * CLK_PERIOD);
    $display("timeout: the test sequence did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
